//--- rtl/mulTypesPkg.sv
// multiply unit data types
// widths, step counts and the multiplier state encoding

package mulTypesPkg;

	// ========================================================================
	// datapath widths
	// ========================================================================

	// one register word
	localparam int dataWidth = 64;
	// full product, two words
	localparam int prodWidth = 2 * dataWidth;
	// destination register number
	localparam int regAddrWidth = 5;

	// ========================================================================
	// iterative multiplier steps
	// ========================================================================

	// multiplier bits consumed per step, a quarter word
	localparam int stepBits = dataWidth / 4;
	// steps needed to consume the whole multiplier
	localparam int stepCount = dataWidth / stepBits;
	// step counter has to hold stepCount itself
	localparam int stepCntWidth = $clog2(stepCount + 1);

	// multiplier FSM states
	typedef enum logic [2:0] {
		mult = 3'd3,
		idle = 3'd4,
		done = 3'd5
	} mulState;

endpackage

//--- rtl/mulOpcodesPkg.sv
// multiply instruction encoding
// field positions and the opcodes handled by the multiply unit

package mulOpcodesPkg;

	// instruction word
	localparam int instrWidth = 32;

	// opcode in bits 6..0
	localparam int opcodeLsb = 0;
	localparam int opcodeWidth = 7;

	// destination register in bits 11..7
	// width comes from the register number width
	localparam int rdLsb = 7;

	// immediate in bits 31..12
	localparam int immLsb = 12;
	localparam int immWidth = 20;

	// register forms, low and high halves
	localparam logic [opcodeWidth-1:0] opMul = 7'h30;
	localparam logic [opcodeWidth-1:0] opMulu = 7'h31;
	localparam logic [opcodeWidth-1:0] opMulh = 7'h32;
	localparam logic [opcodeWidth-1:0] opMulhu = 7'h33;

	// immediate forms, low half only
	localparam logic [opcodeWidth-1:0] opMuli = 7'h34;
	localparam logic [opcodeWidth-1:0] opMului = 7'h35;

endpackage

//--- rtl/mulIssueIf.sv
// multiply issue bus
// one operation from decode to the multiplier, busy back to decode

`timescale 1ns/1ps

interface mulIssueIf import mulTypesPkg::*; ();

	// one cycle start pulse
	logic ld;
	// signed multiply
	logic sgn;
	// take the upper product half
	logic hiSel;
	// destination register
	logic [regAddrWidth-1:0] rd;
	// operands, immediate already folded into bOp
	logic [dataWidth-1:0] aOp;
	logic [dataWidth-1:0] bOp;
	// multiplier not idle
	logic busy;

	// decode side
	modport issuer (
		output ld, sgn, hiSel, rd, aOp, bOp,
		input busy
	);

	// multiplier side
	modport worker (
		input ld, sgn, aOp, bOp,
		output busy
	);

	// result stage only needs the writeback selectors
	// they hold while the operation is in flight
	modport observer (
		input hiSel, rd
	);

endinterface

//--- rtl/mulDecode.sv
// multiply decode
// checks the opcode, picks the operands and issues a one cycle load

`timescale 1ns/1ps

module mulDecode import mulTypesPkg::*, mulOpcodesPkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  instrValid,
	input  logic [instrWidth-1:0] instr,
	input  logic [dataWidth-1:0]  aData,
	input  logic [dataWidth-1:0]  bData,
	output logic                  illegal,
	mulIssueIf.issuer             issue
);

	// instruction fields
	logic [opcodeWidth-1:0] opcode;
	logic [regAddrWidth-1:0] rdField;
	logic [immWidth-1:0] immField;

	// immediate widened both ways
	logic [dataWidth-1:0] immSext;
	logic [dataWidth-1:0] immZext;

	// decoded controls
	logic legal;
	logic isSigned;
	logic isHigh;
	logic [dataWidth-1:0] bSel;

	// instruction taken this cycle
	logic accept;

	assign opcode = instr[opcodeLsb +: opcodeWidth];
	assign rdField = instr[rdLsb +: regAddrWidth];
	assign immField = instr[immLsb +: immWidth];

	assign immSext = {{(dataWidth - immWidth){immField[immWidth-1]}}, immField};
	assign immZext = {{(dataWidth - immWidth){1'b0}}, immField};

	// nothing is taken while an operation is pending or running
	// dropped strobes raise no illegal either
	assign accept = instrValid && !issue.busy && !issue.ld;

	// ========================================================================
	// opcode decode
	// ========================================================================

	always_comb begin
		legal = 1'b1;
		isSigned = 1'b0;
		isHigh = 1'b0;
		bSel = bData;
		case (opcode)
			opMul: isSigned = 1'b1;
			opMulu: ;
			opMulh: begin
				isSigned = 1'b1;
				isHigh = 1'b1;
			end
			opMulhu: isHigh = 1'b1;
			// immediate forms replace the second register
			opMuli: begin
				isSigned = 1'b1;
				bSel = immSext;
			end
			opMului: bSel = immZext;
			default: legal = 1'b0;
		endcase
	end

	// ========================================================================
	// issue registers
	// ========================================================================

	// strobes and selectors
	always_ff @(posedge clk) begin
		if (rst) begin
			issue.ld <= 1'b0;
			illegal <= 1'b0;
			issue.sgn <= 1'b0;
			issue.hiSel <= 1'b0;
			issue.rd <= '0;
		end else begin
			issue.ld <= accept && legal;
			illegal <= accept && !legal;
			// selectors only move on an issue so the result stage can read them late
			if (accept && legal) begin
				issue.sgn <= isSigned;
				issue.hiSel <= isHigh;
				issue.rd <= rdField;
			end
		end
	end

	// operand values
	always_ff @(posedge clk) begin
		if (accept && legal) begin
			issue.aOp <= aData;
			issue.bOp <= bSel;
		end
	end

endmodule

//--- rtl/multiplier.sv
// iterative 64x64 multiplier
// signed or unsigned, 16 multiplier bits per step, four steps

`timescale 1ns/1ps

module multiplier import mulTypesPkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	mulIssueIf.worker            issue,
	output logic [prodWidth-1:0] o,
	output logic                 done
);

	// width of one partial product, a word times one step of multiplier
	localparam int partWidth = dataWidth + stepBits;

	mulState state;
	logic [stepCntWidth-1:0] cnt;
	logic cntDone;

	// multiplier, shifted down as it is consumed
	logic [dataWidth-1:0] aa;
	// multiplicand
	logic [dataWidth-1:0] bb;
	// product sign
	logic so;
	// running product
	logic [prodWidth-1:0] prod;
	// one step result
	logic [partWidth-1:0] p1;

	assign cntDone = cnt == '0;

	// multiplicand times the low step of the multiplier
	// plus the upper word of the running product
	assign p1 = {{stepBits{1'b0}}, bb} * {{dataWidth{1'b0}}, aa[stepBits-1:0]}
		+ {{stepBits{1'b0}}, prod[prodWidth-1:dataWidth]};

	// done lasts the one cycle spent in the done state
	assign done = state == mulTypesPkg::done;
	assign issue.busy = state != idle;

	// ========================================================================
	// FSM
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			cnt <= '0;
		end else begin
			case (state)
				idle: begin
					if (issue.ld) begin
						cnt <= stepCntWidth'(stepCount);
						state <= mult;
					end
				end
				mult: begin
					// one step per count, then one cycle to write o
					if (!cntDone) begin
						cnt <= cnt - stepCntWidth'(1);
					end else begin
						state <= mulTypesPkg::done;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// ========================================================================
	// datapath
	// ========================================================================

	always_ff @(posedge clk) begin
		case (state)
			idle: begin
				if (issue.ld) begin
					if (issue.sgn) begin
						// work on magnitudes, sign comes back at the end
						aa <= issue.aOp[dataWidth-1] ? -issue.aOp : issue.aOp;
						bb <= issue.bOp[dataWidth-1] ? -issue.bOp : issue.bOp;
						so <= issue.aOp[dataWidth-1] ^ issue.bOp[dataWidth-1];
					end else begin
						aa <= issue.aOp;
						bb <= issue.bOp;
						so <= 1'b0;
					end
					prod <= '0;
				end
			end
			mult: begin
				if (!cntDone) begin
					// consume one step of multiplier
					aa <= {{stepBits{1'b0}}, aa[dataWidth-1:stepBits]};
					// new upper part on top, old product slides down one step
					prod <= {p1, prod[dataWidth-1:stepBits]};
				end else begin
					// unsigned operations always have so low
					o <= so ? -prod : prod;
				end
			end
			default: ;
		endcase
	end

endmodule

//--- rtl/mulResult.sv
// multiply result stage
// picks the product half and registers the writeback

`timescale 1ns/1ps

module mulResult import mulTypesPkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [prodWidth-1:0]    o,
	input  logic                    done,
	mulIssueIf.observer             issue,
	output logic                    resultValid,
	output logic [regAddrWidth-1:0] resultRd,
	output logic [dataWidth-1:0]    resultData
);

	// product half chosen by hiSel
	logic [dataWidth-1:0] halfSel;

	assign halfSel = issue.hiSel ? o[prodWidth-1:dataWidth] : o[dataWidth-1:0];

	// ========================================================================
	// writeback register
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			resultValid <= 1'b0;
			resultRd <= '0;
			resultData <= '0;
		end else begin
			// done is a single cycle so this is a single cycle too
			resultValid <= done;
			// data and rd hold until the next result
			if (done) begin
				resultRd <= issue.rd;
				resultData <= halfSel;
			end
		end
	end

endmodule

//--- rtl/mulUnit.sv
// multiply unit top level
// decode, iterative multiplier and result stage

`timescale 1ns/1ps

module mulUnit import mulTypesPkg::*, mulOpcodesPkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	// instruction strobe and the register values read for it
	input  logic                    instrValid,
	input  logic [instrWidth-1:0]   instr,
	input  logic [dataWidth-1:0]    aData,
	input  logic [dataWidth-1:0]    bData,
	// unknown opcode seen
	output logic                    illegal,
	// instructions are dropped while this is high
	output logic                    busy,
	// writeback
	output logic                    resultValid,
	output logic [regAddrWidth-1:0] resultRd,
	output logic [dataWidth-1:0]    resultData
);

	// full product from the multiplier
	logic [prodWidth-1:0] prod;
	logic prodDone;

	// decode to multiplier and result stage
	mulIssueIf issueBus ();

	assign busy = issueBus.busy;

	// ========================================================================
	// pipeline
	// ========================================================================

	mulDecode iDecode (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.aData      (aData),
		.bData      (bData),
		.illegal    (illegal),
		.issue      (issueBus.issuer)
	);

	// ld one cycle after the strobe, done six cycles after ld
	multiplier iMultiplier (
		.clk   (clk),
		.rst   (rst),
		.issue (issueBus.worker),
		.o     (prod),
		.done  (prodDone)
	);

	mulResult iResult (
		.clk         (clk),
		.rst         (rst),
		.o           (prod),
		.done        (prodDone),
		.issue       (issueBus.observer),
		.resultValid (resultValid),
		.resultRd    (resultRd),
		.resultData  (resultData)
	);

endmodule

//--- testbench/mulUnitTb.sv
// multiply unit testbench
// replays the vector file and checks results, latency, busy and dropped strobes

`timescale 1ns/1ps

module mulUnitTb import mulTypesPkg::*, mulOpcodesPkg::*;;

	// vector file layout, six hex words per vector
	localparam int vecCount = 20;
	localparam int wordsPerVec = 6;
	// edges from the sampled strobe to resultValid
	localparam int resultLatency = 7;
	// longest wait for any response
	localparam int waitLimit = 20;
	// edge at which the extra strobe is sampled in the drop test
	localparam int dropEdge = 3;

	logic clk;
	logic rst;
	logic instrValid;
	logic [instrWidth-1:0] instr;
	logic [dataWidth-1:0] aData;
	logic [dataWidth-1:0] bData;
	logic illegal;
	logic busy;
	logic resultValid;
	logic [regAddrWidth-1:0] resultRd;
	logic [dataWidth-1:0] resultData;

	// instr, aData, bData, expected data, expected rd, illegal flag
	logic [dataWidth-1:0] vecMem [0:vecCount*wordsPerVec-1];

	int errors;
	int checks;
	int vecIdx;

	mulUnit i_dut (
		.clk         (clk),
		.rst         (rst),
		.instrValid  (instrValid),
		.instr       (instr),
		.aData       (aData),
		.bData       (bData),
		.illegal     (illegal),
		.busy        (busy),
		.resultValid (resultValid),
		.resultRd    (resultRd),
		.resultData  (resultData)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// ========================================================================
	// helpers
	// ========================================================================

	// step past the next rising edge to where inputs change and outputs settle
	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	// compare one observed value with its expected value
	task automatic expectValue(input string name, input logic [dataWidth-1:0] got,
			input logic [dataWidth-1:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAILED %s: expected %h, got %h (vector %0d)", name, exp, got, vecIdx);
		end
	endtask

	// condition that has no single value to show
	task automatic confirm(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("%s (vector %0d)", what, vecIdx);
		end
	endtask

	// one strobe, then watch the unit until it answers or the wait runs out
	// withDrop adds two more strobes while the first one is in flight
	task automatic runVector(input int idx, input bit withDrop);
		int base;
		int cycles;
		bit seen;
		logic [dataWidth-1:0] expData;
		logic [regAddrWidth-1:0] expRd;
		logic expIllegal;
		base = idx * wordsPerVec;
		expData = vecMem[base+3];
		expRd = vecMem[base+4][regAddrWidth-1:0];
		expIllegal = vecMem[base+5][0];
		instr = vecMem[base][instrWidth-1:0];
		aData = vecMem[base+1];
		bData = vecMem[base+2];
		instrValid = 1'b1;
		// edge 0 samples the strobe
		nextCycle();
		instrValid = 1'b0;
		expectValue("illegal", dataWidth'(illegal), dataWidth'(expIllegal));
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < waitLimit) begin
			// extra mulu to r30, the unit is busy and has to drop it
			if (withDrop && cycles == dropEdge - 1) begin
				instr = {immWidth'(0), regAddrWidth'(30), opMulu};
				instrValid = 1'b1;
			end
			// then an unknown opcode, dropped without an illegal pulse
			if (withDrop && cycles == dropEdge) begin
				instr = {immWidth'(0), regAddrWidth'(30), {opcodeWidth{1'b1}}};
				instrValid = 1'b1;
			end
			nextCycle();
			instrValid = 1'b0;
			cycles++;
			seen = resultValid;
			// busy from edge 1 up to the edge that raises resultValid
			expectValue("busy", dataWidth'(busy),
				dataWidth'(!expIllegal && cycles < resultLatency));
			// illegal is a single pulse and dropped strobes never raise it
			expectValue("illegal", dataWidth'(illegal), '0);
		end
		if (expIllegal) begin
			confirm(!seen, "illegal opcode produced a result");
		end else begin
			confirm(seen, "no resultValid before the timeout");
			if (seen) begin
				expectValue("resultValid latency", dataWidth'(cycles),
					dataWidth'(resultLatency));
				expectValue("resultRd", dataWidth'(resultRd), dataWidth'(expRd));
				expectValue("resultData", resultData, expData);
			end
		end
		// the dropped strobe must not come out later either
		if (withDrop) begin
			repeat (waitLimit) begin
				nextCycle();
				confirm(!resultValid, "dropped instruction produced a result");
			end
		end
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		aData = '0;
		bData = '0;
		errors = 0;
		checks = 0;
		vecIdx = 0;
		$readmemh("testbench/mulUnitInput.txt", vecMem);
		confirm(!$isunknown(vecMem[vecCount*wordsPerVec-1]), "vector file is too short");

		// reset for 4 cycles
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;

		// idle outputs before any strobe
		expectValue("busy", dataWidth'(busy), '0);
		expectValue("illegal", dataWidth'(illegal), '0);
		expectValue("resultValid", dataWidth'(resultValid), '0);
		expectValue("resultData", resultData, '0);

		for (vecIdx = 0; vecIdx < vecCount; vecIdx++) begin
			runVector(vecIdx, 1'b0);
		end

		// first vector again, with strobes 3 and 4 cycles into the operation
		vecIdx = 0;
		runVector(0, 1'b1);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- testbench/mulUnitInput.txt
// columns: instr aData bData expected_resultData expected_rd illegal_flag
// one vector per line, all hex; instr = imm[31:12] rd[11:7] opcode[6:0]
000000b1 0000000000000003 0000000000000005 000000000000000f 01 0
00000131 ffffffffffffffff ffffffffffffffff 0000000000000001 02 0
000001b3 ffffffffffffffff ffffffffffffffff fffffffffffffffe 03 0
00000233 0000000100000000 0000000100000000 0000000000000001 04 0
000002b1 0000000123456789 0000000000000010 0000001234567890 05 0
00000333 ffffffffffffffff 0000000000000002 0000000000000001 06 0
000003b0 0000000000000006 0000000000000007 000000000000002a 07 0
00000430 fffffffffffffffa 0000000000000007 ffffffffffffffd6 08 0
000004b2 fffffffffffffffa 0000000000000007 ffffffffffffffff 09 0
00000530 0000000000000006 fffffffffffffff9 ffffffffffffffd6 0a 0
000005b2 fffffffffffffffa fffffffffffffff9 0000000000000000 0b 0
00000630 fffffffffffffffa fffffffffffffff9 000000000000002a 0c 0
000006b2 8000000000000000 0000000000000002 ffffffffffffffff 0d 0
00000732 4000000000000000 0000000000000004 0000000000000001 0e 0
ffffd7b4 0000000000000005 0123456789abcdef fffffffffffffff1 0f 0
ffffd835 0000000000000005 0123456789abcdef 00000000004ffff1 10 0
000108b4 ffffffffffffffff 0123456789abcdef fffffffffffffff0 11 0
00000936 0000000000000003 0000000000000005 0000000000000000 00 1
80000fb4 0000000000000002 0123456789abcdef fffffffffff00000 1f 0
80000a35 0000000000000002 0123456789abcdef 0000000000100000 14 0

//--- compile.f
rtl/mulTypesPkg.sv
rtl/mulOpcodesPkg.sv
rtl/mulIssueIf.sv
rtl/mulDecode.sv
rtl/multiplier.sv
rtl/mulResult.sv
rtl/mulUnit.sv
testbench/mulUnitTb.sv

//--- run.sh
#!/bin/sh
# build the multiply unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module mulUnitTb -f compile.f -o mulUnitSim
out=$(./obj_dir/mulUnitSim)
echo "$out"
if echo "$out" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
exit 1
